//--- verilog/llrf_slow_pkg.sv
`default_nettype none

package llrf_slow_pkg;

	// Raw ADC sample width, also used for the min/max words
	localparam int sample_w = 16;

	// Controller tag, copied into the snapshot twice (now and old)
	localparam int tag_w = 8;

	// Comparator event vector from the controller
	localparam int event_w = 12;

	// Sticky status word, events zero-extended up to a full 16 bits
	localparam int status_w = 16;

	// Free-running cycle counter
	localparam int stamp_w = 64;

	// Narrow slow readout path
	localparam int byte_w = 8;

	// Six min/max words, status, tag_now and tag_old
	localparam int snap_bytes = 16;

	// Timestamp bytes that trail the snapshot on the chain
	localparam int stamp_bytes = 8;

	typedef logic signed [sample_w-1:0] adc_sample_t;
	typedef logic [tag_w-1:0] tag_t;
	typedef logic [event_w-1:0] event_t;
	typedef logic [status_w-1:0] status_t;
	typedef logic [stamp_w-1:0] stamp_t;
	typedef logic [byte_w-1:0] slow_byte_t;

endpackage

`default_nettype wire

//--- verilog/adc_minmax.sv
`default_nettype none

// Running signed min/max of one raw ADC stream
// The snapshot strobe restarts both trackers from the current sample
module adc_minmax (
	input wire logic clk,
	input wire logic rst,
	input wire logic snap,
	input wire llrf_slow_pkg::adc_sample_t xin,
	output llrf_slow_pkg::adc_sample_t xmin,
	output llrf_slow_pkg::adc_sample_t xmax
);

	import llrf_slow_pkg::*;

	// Empty-tracker values: min starts at the top of the range,
	// max starts at the bottom, so the first sample wins both
	localparam adc_sample_t min_empty = adc_sample_t'({1'b0, {(sample_w-1){1'b1}}});
	localparam adc_sample_t max_empty = adc_sample_t'({1'b1, {(sample_w-1){1'b0}}});

	// Signed compares against the held extremes
	logic below;
	logic above;

	assign below = xin < xmin;
	assign above = xin > xmax;

	always_ff @(posedge clk) begin
		if (rst) begin
			xmin <= min_empty;
			xmax <= max_empty;
		end else if (snap) begin
			// New window starts with this cycle's sample
			xmin <= xin;
			xmax <= xin;
		end else begin
			if (below) begin
				xmin <= xin;
			end
			if (above) begin
				xmax <= xin;
			end
		end
	end

	// A fresh window holds exactly one sample, so the extremes agree
	assert property (@(posedge clk) disable iff (rst)
		snap |=> (xmin == xmax))
		else $error("adc_minmax: xmin and xmax differ right after snapshot");

endmodule

`default_nettype wire

//--- verilog/timestamp_chain.sv
`default_nettype none

// Free-running cycle counter plus a byte-wide capture/shift register
// Captured on snapshot, then fed up the slow chain behind the snapshot bytes
module timestamp_chain (
	input wire logic clk,
	input wire logic rst,
	input wire logic snap,
	input wire logic shift,
	output wire llrf_slow_pkg::slow_byte_t stamp_byte
);

	import llrf_slow_pkg::*;

	// Cycle count since reset, zero in the first cycle after rst
	stamp_t count;

	// Byte-addressed capture register, top byte leaves first
	logic [stamp_bytes-1:0][byte_w-1:0] stamp_sr;

	always_ff @(posedge clk) begin
		if (rst) begin
			count <= '0;
		end else begin
			count <= count + stamp_t'(1);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			stamp_sr <= '0;
		end else if (snap) begin
			// Counter value at the snap cycle itself
			stamp_sr <= count;
		end else if (shift) begin
			// Move up one byte, zeros trail the last timestamp byte
			stamp_sr <= {stamp_sr[stamp_bytes-2:0], slow_byte_t'(0)};
		end
	end

	// Most significant byte goes out first
	assign stamp_byte = stamp_sr[stamp_bytes-1];

	// Outside reset the counter steps by exactly one each cycle
	assert property (@(posedge clk) disable iff (rst)
		!$past(rst) |-> (count == stamp_t'($past(count) + stamp_t'(1))))
		else $error("timestamp_chain: cycle counter skipped");

endmodule

`default_nettype wire

//--- verilog/slow_readout.sv
`default_nettype none

// Slow readout register for the controller shell
// Holds the sticky comparator status, the previous tag and the
// 16-byte snapshot shift register whose top byte drives slow_out
module slow_readout (
	input wire logic clk,
	input wire logic rst,
	input wire logic snap,
	input wire logic shift,
	input wire llrf_slow_pkg::adc_sample_t adc1_min,
	input wire llrf_slow_pkg::adc_sample_t adc1_max,
	input wire llrf_slow_pkg::adc_sample_t adc2_min,
	input wire llrf_slow_pkg::adc_sample_t adc2_max,
	input wire llrf_slow_pkg::adc_sample_t adc3_min,
	input wire llrf_slow_pkg::adc_sample_t adc3_max,
	input wire llrf_slow_pkg::event_t cmp_event,
	input wire llrf_slow_pkg::tag_t tag_now,
	input wire llrf_slow_pkg::slow_byte_t stamp_byte,
	output wire llrf_slow_pkg::slow_byte_t slow_out
);

	import llrf_slow_pkg::*;

	// Sticky latch of comparator events since the last snapshot
	status_t status;

	// Tag as it stood at the previous snapshot
	tag_t tag_old;

	// Events padded out to the status width
	status_t event_ext;

	// Parallel load image for the snapshot register
	logic [snap_bytes*byte_w-1:0] snap_data;

	// Snapshot register, one entry per byte, top entry leaves first
	logic [snap_bytes-1:0][byte_w-1:0] snap_sr;

	assign event_ext = {{(status_w-event_w){1'b0}}, cmp_event};

	// Top byte first: min/max pairs, status, then the two tags
	assign snap_data = {
		adc1_min, adc1_max,
		adc2_min, adc2_max,
		adc3_min, adc3_max,
		status, tag_now, tag_old
	};

	// Status restarts with this cycle's events on snap,
	// so events seen in the snap cycle land in the next snapshot
	always_ff @(posedge clk) begin
		if (rst) begin
			status <= '0;
		end else if (snap) begin
			status <= event_ext;
		end else begin
			status <= status | event_ext;
		end
	end

	// tag_now at one snapshot becomes tag_old at the next
	always_ff @(posedge clk) begin
		if (rst) begin
			tag_old <= '0;
		end else if (snap) begin
			tag_old <= tag_now;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			snap_sr <= '0;
		end else if (snap) begin
			snap_sr <= snap_data;
		end else if (shift) begin
			// Timestamp bytes enter at the bottom behind the snapshot
			snap_sr <= {snap_sr[snap_bytes-2:0], stamp_byte};
		end
	end

	assign slow_out = snap_sr[snap_bytes-1];

	// Load and shift come from one slow_op, decoded in the shell
	assert property (@(posedge clk) disable iff (rst)
		!(snap && shift))
		else $error("slow_readout: snap and shift asserted together");

endmodule

`default_nettype wire

//--- verilog/llrf_slow_shell.sv
`default_nettype none

// Slow readout side of the LLRF controller shell
// Three ADC min/max trackers, a timestamp chain and the snapshot
// register, all read out byte-serially through slow_out
module llrf_slow_shell (
	input wire logic clk,
	input wire logic rst,
	input wire llrf_slow_pkg::adc_sample_t a_field,
	input wire llrf_slow_pkg::adc_sample_t a_forward,
	input wire llrf_slow_pkg::adc_sample_t a_reflect,
	input wire llrf_slow_pkg::tag_t tag_now,
	input wire llrf_slow_pkg::event_t cmp_event,
	input wire logic slow_op,
	input wire logic slow_snap,
	output wire llrf_slow_pkg::slow_byte_t slow_out
);

	import llrf_slow_pkg::*;

	// Readout strobes: slow_op qualifies everything,
	// slow_snap picks load over shift
	logic snap;
	logic shift;

	// Tracker outputs toward the readout register
	adc_sample_t adc1_min;
	adc_sample_t adc1_max;
	adc_sample_t adc2_min;
	adc_sample_t adc2_max;
	adc_sample_t adc3_min;
	adc_sample_t adc3_max;

	// Timestamp byte feeding the bottom of the snapshot register
	slow_byte_t stamp_byte;

	assign snap = slow_op & slow_snap;
	assign shift = slow_op & ~slow_snap;

	// Field probe
	adc_minmax mm_field (
		.clk(clk),
		.rst(rst),
		.snap(snap),
		.xin(a_field),
		.xmin(adc1_min),
		.xmax(adc1_max)
	);

	// Forward power
	adc_minmax mm_forward (
		.clk(clk),
		.rst(rst),
		.snap(snap),
		.xin(a_forward),
		.xmin(adc2_min),
		.xmax(adc2_max)
	);

	// Reflected power
	adc_minmax mm_reflect (
		.clk(clk),
		.rst(rst),
		.snap(snap),
		.xin(a_reflect),
		.xmin(adc3_min),
		.xmax(adc3_max)
	);

	timestamp_chain timestamp_chain_inst (
		.clk(clk),
		.rst(rst),
		.snap(snap),
		.shift(shift),
		.stamp_byte(stamp_byte)
	);

	slow_readout slow_readout_inst (
		.clk(clk),
		.rst(rst),
		.snap(snap),
		.shift(shift),
		.adc1_min(adc1_min),
		.adc1_max(adc1_max),
		.adc2_min(adc2_min),
		.adc2_max(adc2_max),
		.adc3_min(adc3_min),
		.adc3_max(adc3_max),
		.cmp_event(cmp_event),
		.tag_now(tag_now),
		.stamp_byte(stamp_byte),
		.slow_out(slow_out)
	);

endmodule

`default_nettype wire

//--- tb/tb_clock.sv
`default_nettype none

// Clock and reset source for the slow readout testbench
module tb_clock (
	output logic clk,
	output logic rst
);

	// 100 time unit period
	localparam int half_period = 50;

	// Reset spans the first 8 rising edges
	localparam int reset_cycles = 8;

	initial begin
		clk = 1'b0;
		forever #half_period clk = ~clk;
	end

	initial begin
		rst = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

`default_nettype wire

//--- tb/llrf_slow_shell_tb.sv
`default_nettype none

// Testbench for the LLRF slow readout shell
module llrf_slow_shell_tb;

	import llrf_slow_pkg::*;

	// Same reset length as tb_clock
	localparam int reset_cycles = 8;
	localparam int stream_bytes = snap_bytes + stamp_bytes;
	// Two reads past the stream end to see the zero tail
	localparam int read_bytes = stream_bytes + 2;
	localparam int num_snaps = 12;
	localparam int max_fill = 20;
	localparam int max_gap = 3;
	// Longest snapshot test is the fill window plus snap plus spaced reads
	localparam int max_snap_len = max_fill + 1 + read_bytes * (max_gap + 1);
	localparam int test_cycles = reset_cycles + (num_snaps + 1) * max_snap_len + 4;
	localparam int cycle_limit = 2 * test_cycles + 200;

	// Event patterns for one cycle
	localparam int ev_none = 0;
	localparam int ev_sparse = 1;
	localparam int ev_forced = 2;

	// Most positive and most negative sample values
	localparam adc_sample_t min_empty = adc_sample_t'((1 << (sample_w - 1)) - 1);
	localparam adc_sample_t max_empty = adc_sample_t'(-(1 << (sample_w - 1)));

	logic clk;
	logic rst;
	adc_sample_t a_field;
	adc_sample_t a_forward;
	adc_sample_t a_reflect;
	tag_t tag_now;
	event_t cmp_event;
	logic slow_op;
	logic slow_snap;
	slow_byte_t slow_out;

	// Inputs the DUT samples at the next rising edge
	adc_sample_t cur_adc [3];
	tag_t cur_tag;
	event_t cur_event;
	logic cur_op;
	logic cur_snap;

	// Reference model state
	adc_sample_t ref_min [3];
	adc_sample_t ref_max [3];
	status_t ref_status;
	tag_t ref_tag_old;
	stamp_t ref_count;
	logic [stream_bytes*byte_w-1:0] exp_stream;
	int exp_idx;
	slow_byte_t exp_out;
	logic model_valid;
	int snap_count;

	int errors;
	int checks;
	int cycles;
	logic [31:0] rng_state;

	tb_clock clock_gen (
		.clk(clk),
		.rst(rst)
	);

	llrf_slow_shell llrf_slow_shell_inst (
		.clk(clk),
		.rst(rst),
		.a_field(a_field),
		.a_forward(a_forward),
		.a_reflect(a_reflect),
		.tag_now(tag_now),
		.cmp_event(cmp_event),
		.slow_op(slow_op),
		.slow_snap(slow_snap),
		.slow_out(slow_out)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic draw_bits(output logic [31:0] bits);
		rng_state = xorshift32(rng_state);
		bits = rng_state;
	endtask

	// Uniform-ish value in 0 .. limit-1
	task automatic draw(input int limit, output int value);
		rng_state = xorshift32(rng_state);
		value = int'(rng_state % 32'(limit));
	endtask

	// Full 24-byte readout for one snapshot with byte 0 in the top bits
	function automatic logic [stream_bytes*byte_w-1:0] expected_stream(
		input adc_sample_t mins [3],
		input adc_sample_t maxs [3],
		input status_t status,
		input tag_t tag_cur,
		input tag_t tag_prev,
		input stamp_t stamp
	);
		return {mins[0], maxs[0], mins[1], maxs[1], mins[2], maxs[2],
			status, tag_cur, tag_prev, stamp};
	endfunction

	// Behavior covered by a given stream position
	function automatic string byte_test_name(input int idx);
		if (idx < 0) begin
			return "reset_idle";
		end else if (idx < 12) begin
			return "minmax";
		end else if (idx < 14) begin
			return "status";
		end else if (idx < 16) begin
			return "tags";
		end else if (idx < stream_bytes) begin
			return "timestamp";
		end
		return "zero_tail";
	endfunction

	// Model of one rising edge with the inputs sampled there
	task automatic model_edge();
		logic snap;
		logic shift;
		status_t ev_ext;
		snap = cur_op && cur_snap;
		shift = cur_op && !cur_snap;
		ev_ext = status_t'(cur_event);
		if (rst) begin
			for (int i = 0; i < 3; i++) begin
				ref_min[i] = min_empty;
				ref_max[i] = max_empty;
			end
			ref_status = '0;
			ref_tag_old = '0;
			ref_count = '0;
			exp_idx = -1;
		end else begin
			if (snap) begin
				// Snapshot shows the window up to the cycle before
				exp_stream = expected_stream(ref_min, ref_max, ref_status,
					cur_tag, ref_tag_old, ref_count);
				exp_idx = 0;
				snap_count++;
				for (int i = 0; i < 3; i++) begin
					ref_min[i] = cur_adc[i];
					ref_max[i] = cur_adc[i];
				end
				ref_status = ev_ext;
				ref_tag_old = cur_tag;
			end else begin
				for (int i = 0; i < 3; i++) begin
					if (cur_adc[i] < ref_min[i]) begin
						ref_min[i] = cur_adc[i];
					end
					if (cur_adc[i] > ref_max[i]) begin
						ref_max[i] = cur_adc[i];
					end
				end
				ref_status = ref_status | ev_ext;
				if (shift && exp_idx >= 0 && exp_idx < stream_bytes) begin
					exp_idx++;
				end
			end
			ref_count = ref_count + stamp_t'(1);
		end
		if (exp_idx < 0 || exp_idx >= stream_bytes) begin
			exp_out = '0;
		end else begin
			exp_out = exp_stream[(stream_bytes-1-exp_idx)*byte_w +: byte_w];
		end
		model_valid = 1'b1;
	endtask

	// Waits for a rising edge, updates the model and sets up the next inputs
	task automatic drive_cycle(input logic op, input logic snp, input int ev_mode);
		logic [31:0] bits;
		int pick;
		@(posedge clk);
		model_edge();
		for (int i = 0; i < 3; i++) begin
			draw_bits(bits);
			cur_adc[i] = adc_sample_t'(bits[15:0]);
		end
		draw_bits(bits);
		cur_tag = bits[23:16];
		cur_event = '0;
		if (ev_mode == ev_forced) begin
			cur_event = event_t'(bits[11:0]) | event_t'(1);
		end else if (ev_mode == ev_sparse) begin
			draw(8, pick);
			if (pick == 0) begin
				draw(event_w, pick);
				cur_event = event_t'(1) << pick;
			end
		end
		cur_op = op;
		cur_snap = snp;
		a_field <= cur_adc[0];
		a_forward <= cur_adc[1];
		a_reflect <= cur_adc[2];
		tag_now <= cur_tag;
		cmp_event <= cur_event;
		slow_op <= op;
		slow_snap <= snp;
	endtask

	// Shifts spaced by random idle gaps that sometimes carry a stray slow_snap
	task automatic read_out();
		int gap;
		int stray;
		for (int b = 0; b < read_bytes; b++) begin
			draw(max_gap + 1, gap);
			for (int g = 0; g < gap; g++) begin
				draw(4, stray);
				drive_cycle(1'b0, stray == 0, ev_sparse);
			end
			drive_cycle(1'b1, 1'b0, ev_sparse);
		end
	endtask

	task automatic run_snapshot(input int fill, input logic snap_event);
		int stray;
		for (int c = 0; c < fill; c++) begin
			draw(6, stray);
			drive_cycle(1'b0, stray == 0, ev_sparse);
		end
		// Events in the snap cycle belong to the next snapshot
		drive_cycle(1'b1, 1'b1, snap_event ? ev_forced : ev_sparse);
		read_out();
	endtask

	// Registered slow_out is stable on the falling edge
	always @(negedge clk) begin
		if (model_valid) begin
			checks++;
			if (slow_out !== exp_out) begin
				errors++;
				$display("CHECK FAILED %s: snapshot %0d byte %0d expected %02h actual %02h",
					byte_test_name(exp_idx), snap_count, exp_idx, exp_out, slow_out);
			end
		end
	end

	initial begin
		int fill;
		rng_state = 32'd86000;
		errors = 0;
		checks = 0;
		snap_count = 0;
		model_valid = 1'b0;
		exp_idx = -1;
		exp_out = '0;
		for (int i = 0; i < 3; i++) begin
			cur_adc[i] = '0;
		end
		cur_tag = '0;
		cur_event = '0;
		cur_op = 1'b0;
		cur_snap = 1'b0;
		a_field <= '0;
		a_forward <= '0;
		a_reflect <= '0;
		tag_now <= '0;
		cmp_event <= '0;
		slow_op <= 1'b0;
		slow_snap <= 1'b0;
		// Idle through reset, then snap on the first edge out of reset
		// so that the trackers still hold their empty values
		for (int i = 0; i < reset_cycles - 1; i++) begin
			drive_cycle(1'b0, 1'b0, ev_none);
		end
		drive_cycle(1'b1, 1'b1, ev_none);
		read_out();
		for (int s = 0; s < num_snaps; s++) begin
			draw(max_fill, fill);
			run_snapshot(fill + 1, s % 2 == 1);
		end
		drive_cycle(1'b0, 1'b0, ev_none);
		// Last compare happens on this falling edge
		@(negedge clk);
		@(posedge clk);
		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	// Watchdog on total run length
	initial begin
		cycles = 0;
		while (cycles < cycle_limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: run did not finish within %0d cycles", cycle_limit);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
verilog/llrf_slow_pkg.sv
verilog/adc_minmax.sv
verilog/timestamp_chain.sv
verilog/slow_readout.sv
verilog/llrf_slow_shell.sv
tb/tb_clock.sv
tb/llrf_slow_shell_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the slow readout testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f \
	--top-module llrf_slow_shell_tb -o llrf_slow_shell_tb
build_status=$?
if [ "$build_status" -ne 0 ]; then
	echo "Verilator build failed with status $build_status"
	exit 1
fi

sim_out=$(./obj_dir/llrf_slow_shell_tb)
sim_status=$?
echo "$sim_out"
if [ "$sim_status" -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -qx "TESTS PASSED"; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1
